//--- hw/branch_pkg.sv
package branch_pkg;

  localparam int xlen    = 32;
  localparam int chunk_w = 4; // bits per comparator slice.

  // major opcodes in instr[6:0].
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // branch func3 in instr[14:12].
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [1:0] {
    kind_none,
    kind_branch,
    kind_jal,
    kind_jalr
  } ctl_kind_t;

  // issue stage payload.
  typedef struct packed {
    logic [31:0]     instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
  } issue_t;

  // execute stage payload after decode and compare.
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1;
    ctl_kind_t       kind;
    logic            cond; // branch condition result.
    logic            illegal;
  } exec_t;

endpackage

//--- hw/chunk_comparator.sv
module chunk_comparator
  import branch_pkg::*;
#(
  parameter int width = 31
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  output logic             eq,
  output logic             lt
);

  localparam int n_chunk = (width + chunk_w - 1) / chunk_w;
  localparam int pad_w   = n_chunk * chunk_w;

  logic [pad_w-1:0]   a_pad;
  logic [pad_w-1:0]   b_pad;
  logic [n_chunk-1:0] eq_s;
  logic [n_chunk-1:0] lt_s;
  logic [n_chunk:0]   hi_eq; // slice i and all above it equal.
  logic [n_chunk-1:0] lt_hit;

  // zero pad the top slice.
  always_comb
  begin
    a_pad = '0;
    b_pad = '0;
    a_pad[width-1:0] = a;
    b_pad[width-1:0] = b;
  end

  assign hi_eq[n_chunk] = 1'b1;

  for (genvar i = 0; i < n_chunk; i++)
  begin : g_slice
    logic [chunk_w-1:0] sa;
    logic [chunk_w-1:0] sb;

    assign sa = a_pad[i*chunk_w +: chunk_w];
    assign sb = b_pad[i*chunk_w +: chunk_w];

    assign eq_s[i] = (sa == sb);
    assign lt_s[i] = (sa < sb);

    assign hi_eq[i]  = hi_eq[i+1] & eq_s[i];
    assign lt_hit[i] = lt_s[i] & hi_eq[i+1]; // only if higher slices tie.
  end

  assign eq = hi_eq[0];
  assign lt = |lt_hit;

endmodule

//--- hw/branch_comparator.sv
module branch_comparator
  import branch_pkg::*;
(
  input  logic [xlen-1:0] rs1,
  input  logic [xlen-1:0] rs2,
  input  logic [2:0]      func3,
  output logic            cond
);

  logic sign_gt;
  logic sign_lt;
  logic sign_eq;
  logic low_eq;
  logic low_lt;
  logic eq;
  logic lt_s;
  logic lt_u;
  logic lt_sel;

  // top bit handled apart from the chunks.
  assign sign_gt = rs1[xlen-1] & ~rs2[xlen-1];
  assign sign_lt = ~rs1[xlen-1] & rs2[xlen-1];
  assign sign_eq = (rs1[xlen-1] == rs2[xlen-1]);

  chunk_comparator #(
    .width(xlen - 1)
  ) low_cmp_inst (
    .a  (rs1[xlen-2:0]),
    .b  (rs2[xlen-2:0]),
    .eq (low_eq),
    .lt (low_lt)
  );

  assign eq   = sign_eq & low_eq;
  assign lt_s = sign_gt | (sign_eq & low_lt); // negative rs1 is smaller.
  assign lt_u = sign_lt | (sign_eq & low_lt);

  assign lt_sel = func3[1] ? lt_u : lt_s;

  // bit 2 picks magnitude, bit 0 inverts.
  assign cond = func3[2] ? (lt_sel ^ func3[0]) : (eq ^ func3[0]);

endmodule

//--- hw/branch_decode.sv
module branch_decode
  import branch_pkg::*;
(
  input  logic [31:0]     instr,
  output ctl_kind_t       kind,
  output logic [xlen-1:0] imm,
  output logic            illegal
);

  logic [6:0]      opcode;
  logic [2:0]      func3;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_i;
  logic            f3_ok;

  assign opcode = instr[6:0];
  assign func3  = instr[14:12];

  // sign extended immediates.
  assign imm_b = {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};

  // the six defined branch conditions.
  always_comb
  begin
    case (func3)
      f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu:
      begin
        f3_ok = 1'b1;
      end
      default:
      begin
        f3_ok = 1'b0; // 010 and 011.
      end
    endcase
  end

  always_comb
  begin
    kind    = kind_none;
    imm     = '0;
    illegal = 1'b0;
    case (opcode)
      op_branch:
      begin
        kind    = kind_branch;
        imm     = imm_b;
        illegal = ~f3_ok;
      end
      op_jal:
      begin
        kind = kind_jal;
        imm  = imm_j;
      end
      op_jalr:
      begin
        kind    = kind_jalr;
        imm     = imm_i;
        illegal = (func3 != 3'b000);
      end
      default:
      begin
        kind = kind_none; // not a control transfer.
      end
    endcase
  end

endmodule

//--- hw/pipe_stage.sv
module pipe_stage #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic load;

  // empty, or the current entry leaves this cycle.
  assign in_ready = ~out_valid | out_ready;
  assign load     = in_valid & in_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid <= 1'b0;
    end
    else if (in_ready)
    begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      out_data <= in_data;
    end
  end

endmodule

//--- hw/branch_target.sv
module branch_target
  import branch_pkg::*;
(
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] rs1,
  input  ctl_kind_t       kind,
  input  logic            cond,
  input  logic            illegal,
  output logic            taken,
  output logic [xlen-1:0] next_pc,
  output logic [xlen-1:0] link,
  output logic            misaligned
);

  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_rel;
  logic [xlen-1:0] reg_rel;
  logic [xlen-1:0] target;

  assign pc_plus4 = pc + xlen'(4);
  assign pc_rel   = pc + imm;
  assign reg_rel  = rs1 + imm;

  // jalr drops bit 0 of the sum.
  assign target = (kind == kind_jalr) ? {reg_rel[xlen-1:1], 1'b0} : pc_rel;

  always_comb
  begin
    case (kind)
      kind_branch:
      begin
        taken = cond & ~illegal;
      end
      kind_jal, kind_jalr:
      begin
        taken = ~illegal; // bad jalr func3 is not followed.
      end
      default:
      begin
        taken = 1'b0;
      end
    endcase
  end

  assign next_pc    = taken ? target : pc_plus4;
  assign link       = pc_plus4;
  assign misaligned = taken & target[1];

endmodule

//--- hw/branch_unit.sv
module branch_unit
  import branch_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            issue_valid,
  output logic            issue_ready,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1,
  input  logic [xlen-1:0] rs2,
  output logic            res_valid,
  input  logic            res_ready,
  output logic            taken,
  output logic [xlen-1:0] next_pc,
  output logic [xlen-1:0] link,
  output logic            illegal,
  output logic            misaligned
);

  issue_t          issue_d;
  issue_t          issue_q;
  logic            issue_q_valid;
  logic            exec_in_ready;
  exec_t           exec_d;
  exec_t           exec_q;
  ctl_kind_t       dec_kind;
  logic [xlen-1:0] dec_imm;
  logic            dec_illegal;
  logic            cmp_cond;

  assign issue_d = '{instr: instr, pc: pc, rs1: rs1, rs2: rs2};

  pipe_stage #(
    .payload_t(issue_t)
  ) issue_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (issue_valid),
    .in_ready  (issue_ready),
    .in_data   (issue_d),
    .out_valid (issue_q_valid),
    .out_ready (exec_in_ready),
    .out_data  (issue_q)
  );

  branch_decode branch_decode_inst (
    .instr   (issue_q.instr),
    .kind    (dec_kind),
    .imm     (dec_imm),
    .illegal (dec_illegal)
  );

  branch_comparator branch_comparator_inst (
    .rs1   (issue_q.rs1),
    .rs2   (issue_q.rs2),
    .func3 (issue_q.instr[14:12]),
    .cond  (cmp_cond)
  );

  assign exec_d = '{
    pc:      issue_q.pc,
    imm:     dec_imm,
    rs1:     issue_q.rs1,
    kind:    dec_kind,
    cond:    cmp_cond,
    illegal: dec_illegal
  };

  pipe_stage #(
    .payload_t(exec_t)
  ) exec_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (issue_q_valid),
    .in_ready  (exec_in_ready),
    .in_data   (exec_d),
    .out_valid (res_valid),
    .out_ready (res_ready),
    .out_data  (exec_q)
  );

  branch_target branch_target_inst (
    .pc         (exec_q.pc),
    .imm        (exec_q.imm),
    .rs1        (exec_q.rs1),
    .kind       (exec_q.kind),
    .cond       (exec_q.cond),
    .illegal    (exec_q.illegal),
    .taken      (taken),
    .next_pc    (next_pc),
    .link       (link),
    .misaligned (misaligned)
  );

  assign illegal = exec_q.illegal;

endmodule

//--- testbench/branch_model.svh
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

typedef struct packed {
  logic        taken;
  logic [31:0] next_pc;
  logic [31:0] link;
  logic        illegal;
  logic        misaligned;
} result_t;

logic [31:0] lfsr = 32'h1619_ff8c;

// fibonacci lfsr with taps 32 22 2 1.
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
  lfsr = {lfsr[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

function automatic logic branch_holds(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
  case (f3)
    f3_beq:  return a == b;
    f3_bne:  return a != b;
    f3_blt:  return $signed(a) < $signed(b);
    f3_bge:  return $signed(a) >= $signed(b);
    f3_bltu: return a < b;
    f3_bgeu: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic result_t expect_result(logic [6:0] op, logic [2:0] f3, logic [31:0] pc_v,
                                          logic [31:0] imm, logic [31:0] a, logic [31:0] b);
  result_t     r;
  logic [31:0] target;
  r.illegal = (op == op_branch && f3[2:1] == 2'b01) || (op == op_jalr && f3 != 3'b000);
  r.taken   = !r.illegal && (op == op_jal || op == op_jalr ||
                             (op == op_branch && branch_holds(f3, a, b)));
  target       = (op == op_jalr) ? ((a + imm) & ~32'd1) : pc_v + imm;
  r.link       = pc_v + 32'd4;
  r.next_pc    = r.taken ? target : r.link;
  r.misaligned = r.taken && target[1];
  return r;
endfunction

function automatic logic [31:0] enc_b(logic [2:0] f3, logic [31:0] imm);
  return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic logic [31:0] enc_j(logic [31:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, op_jal};
endfunction

function automatic logic [31:0] enc_i(logic [2:0] f3, logic [31:0] imm);
  return {imm[11:0], 5'd1, f3, 5'd1, op_jalr};
endfunction

`endif

//--- testbench/branch_unit_tb.sv
module branch_unit_tb
  import branch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_branch   = 6 * 32;
  localparam int n_jump     = 64;
  localparam int n_misc     = 48;
  localparam int n_stall    = 200;
  localparam int n_stream   = 64;
  localparam int max_cycles = 2 * (n_branch + n_jump + n_misc + n_stall + n_stream)
                              + 8 * n_stall + 200; // gaps and stalls.

  logic            clk = 1'b0;
  logic            arst_n;
  logic            issue_valid;
  logic            issue_ready;
  logic [31:0]     instr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1;
  logic [xlen-1:0] rs2;
  logic            res_valid;
  logic            res_ready = 1'b0;
  logic            taken;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] link;
  logic            illegal;
  logic            misaligned;

  `include "branch_model.svh"

  result_t     sb_mem [256];
  logic [7:0]  wr_ptr = '0;
  logic [7:0]  rd_ptr;
  result_t     exp_res;
  logic        res_fire;
  logic        gap_mode = 1'b0;
  logic        stall_mode = 1'b0;
  logic        stream_mode = 1'b0;
  logic        acc_d1;
  logic        acc_d2;
  logic [31:0] pc_next;
  logic [2:0]  f3_list [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
  logic [6:0]  other_ops [4] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0110111};
  int          errors = 0;
  int          err_base = 0;
  int          issued = 0;
  int          results = 0;
  int          tests = 0;
  int          cycles = 0;

  branch_unit branch_unit_inst (.*);

  initial forever #5 clk = ~clk;

  assign res_fire = res_valid & res_ready;
  assign exp_res  = sb_mem[rd_ptr]; // oldest outstanding result.

  function automatic void mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
  endfunction

  function automatic void fault(string what);
    errors++;
    $display("ERROR %0t %s", $time, what);
  endfunction

  assert property (@(posedge clk) !arst_n |-> !res_valid)
    else fault("res_valid high while reset is asserted");
  assert property (@(posedge clk) $rose(arst_n) |-> !res_valid)
    else fault("res_valid high on the first edge after reset");
  assert property (@(posedge clk) disable iff (!arst_n) res_fire |-> wr_ptr != rd_ptr)
    else fault("result arrived with no instruction outstanding");
  assert property (@(posedge clk) disable iff (!arst_n) res_fire |-> taken == exp_res.taken)
    else mismatch("taken", 32'($sampled(exp_res.taken)), 32'($sampled(taken)));
  assert property (@(posedge clk) disable iff (!arst_n) res_fire |-> next_pc == exp_res.next_pc)
    else mismatch("next_pc", $sampled(exp_res.next_pc), $sampled(next_pc));
  assert property (@(posedge clk) disable iff (!arst_n) res_fire |-> link == exp_res.link)
    else mismatch("link", $sampled(exp_res.link), $sampled(link));
  assert property (@(posedge clk) disable iff (!arst_n) res_fire |-> illegal == exp_res.illegal)
    else mismatch("illegal", 32'($sampled(exp_res.illegal)), 32'($sampled(illegal)));
  assert property (@(posedge clk) disable iff (!arst_n)
                   res_fire |-> misaligned == exp_res.misaligned)
    else mismatch("misaligned", 32'($sampled(exp_res.misaligned)), 32'($sampled(misaligned)));
  assert property (@(posedge clk) disable iff (!arst_n) stream_mode |-> issue_ready)
    else fault("issue_ready dropped while streaming");
  assert property (@(posedge clk) disable iff (!arst_n) stream_mode |-> res_valid == acc_d2)
    else fault("result did not follow its issue by two cycles while streaming");

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_ptr <= '0;
      acc_d1 <= 1'b0;
      acc_d2 <= 1'b0;
    end
    else
    begin
      if (res_fire)
      begin
        rd_ptr  <= rd_ptr + 8'd1;
        results <= results + 1;
      end
      acc_d1 <= issue_valid & issue_ready; // accept history.
      acc_d2 <= acc_d1;
    end
  end

  always @(posedge clk)
  begin
    res_ready <= stall_mode ? lfsr_bit() : 1'b1;
    cycles    <= cycles + 1;
    if (cycles > max_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic send_op(input logic [6:0] op, input logic [2:0] f3,
                         input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] ins;
    int          gap;
    r = rand_bits(20);
    case (op)
      op_branch: imm = {{19{r[11]}}, r[11:0], 1'b0};
      op_jal:    imm = {{11{r[19]}}, r[19:0], 1'b0};
      op_jalr:   imm = {{20{r[11]}}, r[11:0]};
      default:   imm = '0;
    endcase
    case (op)
      op_branch: ins = enc_b(f3, imm);
      op_jal:    ins = enc_j(imm);
      op_jalr:   ins = enc_i(f3, imm);
      default:   ins = {r[19:3], f3, r[4:0], op};
    endcase
    gap = gap_mode ? int'(rand_bits(2)) : 0;
    if (gap > 0)
    begin
      issue_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    issue_valid <= 1'b1;
    instr       <= ins;
    pc          <= pc_next;
    rs1         <= a;
    rs2         <= b;
    @(negedge clk);
    while (!issue_ready)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    sb_mem[wr_ptr] <= expect_result(op, f3, pc_next, imm, a, b);
    wr_ptr         <= wr_ptr + 8'd1;
    pc_next = pc_next + 32'd4; // unique link per instruction.
    issued++;
  endtask

  task automatic send_pair(input logic [2:0] f3, input int k);
    logic [31:0] a;
    logic [31:0] b;
    a = rand_bits(32);
    case (k)
      0: b = a;
      1: b = a ^ 32'h0000_0001; // lowest chunk only.
      2: b = a ^ 32'h4000_0000; // highest chunk only.
      3: b = a ^ 32'h8000_0000;
      4:
      begin
        a = 32'h7fff_ffff;
        b = 32'h8000_0000;
      end
      5:
      begin
        a = 32'h8000_0000;
        b = 32'h7fff_ffff;
      end
      default: b = rand_bits(32);
    endcase
    send_op(op_branch, f3, a, b);
  endtask

  task automatic end_test(input string name);
    issue_valid <= 1'b0;
    @(negedge clk);
    while (wr_ptr != rd_ptr)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    tests++;
    $display("test %s: %0d results so far, %0d errors", name, results, errors - err_base);
    err_base = errors;
  endtask

  initial
  begin
    arst_n      = 1'b0;
    issue_valid = 1'b1; // offered while the dut is held in reset.
    instr       = '0;
    pc          = '0;
    rs1         = '0;
    rs2         = '0;
    pc_next     = rand_bits(30) << 2;
    repeat (3) @(posedge clk);
    arst_n      <= 1'b1;
    issue_valid <= 1'b0;
    @(posedge clk);
    end_test("reset");

    foreach (f3_list[i])
    begin
      for (int k = 0; k < n_branch / 6; k++)
      begin
        send_pair(f3_list[i], k % 8);
      end
    end
    end_test("branch_conditions");

    for (int i = 0; i < n_jump; i++)
    begin
      send_op((i % 2 == 0) ? op_jal : op_jalr, 3'b000, rand_bits(32), rand_bits(32));
    end
    end_test("jal_jalr");

    for (int i = 0; i < n_misc; i++)
    begin
      case (i % 3)
        0: send_op(op_branch, 3'(2 + i % 2), rand_bits(32), rand_bits(32));
        1: send_op(op_jalr, 3'(1 + i % 7), rand_bits(32), rand_bits(32));
        default: send_op(other_ops[i % 4], 3'(rand_bits(3)), rand_bits(32), rand_bits(32));
      endcase
    end
    end_test("illegal_and_other");

    gap_mode = 1'b1;
    stall_mode <= 1'b1;
    for (int i = 0; i < n_stall; i++)
    begin
      case (rand_bits(2))
        0: send_op(op_branch, f3_list[i % 6], rand_bits(32), rand_bits(32));
        1: send_op(op_jal, 3'b000, rand_bits(32), rand_bits(32));
        2: send_op(op_jalr, 3'b000, rand_bits(32), rand_bits(32));
        default: send_op(other_ops[i % 4], 3'(rand_bits(3)), rand_bits(32), rand_bits(32));
      endcase
    end
    gap_mode = 1'b0;
    stall_mode <= 1'b0;
    end_test("stall_and_gaps");

    stream_mode <= 1'b1;
    for (int i = 0; i < n_stream; i++)
    begin
      send_op(op_branch, f3_list[i % 6], rand_bits(32), rand_bits(32));
    end
    end_test("back_to_back");
    stream_mode <= 1'b0;

    if (results != issued)
    begin
      fault("number of results differs from number of issued instructions");
    end
    $display("summary: %0d tests, %0d issued, %0d results, %0d errors",
             tests, issued, results, errors);
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- branch_unit.f
+incdir+testbench
hw/branch_pkg.sv
hw/chunk_comparator.sv
hw/branch_comparator.sv
hw/branch_decode.sv
hw/pipe_stage.sv
hw/branch_target.sv
hw/branch_unit.sv
testbench/branch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module branch_unit_tb -Mdir obj_dir -f branch_unit.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vbranch_unit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
